//--- source/isaPkg.sv
// RV32I subset encoding: word types, opcodes and funct3 values imported by the core stages
package isaPkg;

    typedef logic [31:0] word;
    typedef logic [31:0] instrWord;
    typedef logic [4:0]  regAddr;
    typedef logic [6:0]  opcodeT;

    // Opcodes kept in the subset
    localparam opcodeT opRegReg = 7'b0110011;
    localparam opcodeT opRegImm = 7'b0010011;
    localparam opcodeT opLui    = 7'b0110111;
    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opBranch = 7'b1100011;

    // funct3 field values
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Word   = 3'b010;
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;

    localparam word resetPc = 32'h0000_0000;
    localparam word pcStep  = 32'd4;

endpackage

//--- source/controlPkg.sv
// Internal control encodings of the core, shared by the decode, compute and hazard logic
package controlPkg;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt} aluOpT;
    typedef enum logic {srcBReg, srcBImm} operandBSrcT;
    typedef enum logic [1:0] {resultAlu, resultImm, resultMem} resultSrcT;
    typedef enum logic [1:0] {fwdNone, fwdFromM, fwdFromW} forwardSelT;

    // Control carried into the compute stage
    typedef struct packed {
        aluOpT       aluOp;
        operandBSrcT operandBSrc;
        resultSrcT   resultSrc;
        logic        regWrite;
        logic        memRead;
        logic        memWrite;
        logic        isBranch;
        logic        branchOnEqual;
    } ctrlBundle;

    // Part of the control still needed after compute
    typedef struct packed {
        resultSrcT resultSrc;
        logic      regWrite;
        logic      memRead;
        logic      memWrite;
    } memCtrlBundle;

    localparam ctrlBundle ctrlBubble = '{
        aluOp: aluAdd,
        operandBSrc: srcBReg,
        resultSrc: resultAlu,
        regWrite: 1'b0,
        memRead: 1'b0,
        memWrite: 1'b0,
        isBranch: 1'b0,
        branchOnEqual: 1'b0
    };

    localparam memCtrlBundle memCtrlBubble = '{
        resultSrc: resultAlu,
        regWrite: 1'b0,
        memRead: 1'b0,
        memWrite: 1'b0
    };

endpackage

//--- source/hazardIf.sv
// Hazard signals exchanged between the pipeline stages and the hazard unit
`timescale 1ns/1ns
interface hazardIf import isaPkg::*, controlPkg::*; ();

    // Sources of the instruction in R
    regAddr rs1Addr;
    regAddr rs2Addr;

    // Destinations ahead in C and M
    regAddr rdAddrC;
    logic   regWriteC;
    logic   memReadC;
    logic   branchTaken;
    regAddr rdAddrM;
    logic   regWriteM;

    // Decisions of the hazard unit
    forwardSelT forwardA;
    forwardSelT forwardB;
    logic       stallFront;
    logic       flushIr;
    logic       flushRc;

    modport stage (
        output rs1Addr, rs2Addr, rdAddrC, regWriteC, memReadC,
        output branchTaken, rdAddrM, regWriteM,
        input  forwardA, forwardB, stallFront, flushIr, flushRc
    );

    modport ctrl (
        input  rs1Addr, rs2Addr, rdAddrC, regWriteC, memReadC,
        input  branchTaken, rdAddrM, regWriteM,
        output forwardA, forwardB, stallFront, flushIr, flushRc
    );

endinterface

//--- source/registerFile.sv
// Integer register file read in R and written from W, used inside the decode stage
`timescale 1ns/1ns
module registerFile import isaPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  regAddr rs1Addr,
    input  regAddr rs2Addr,
    input  regAddr writeAddr,
    input  logic   writeEn,
    input  word    writeData,
    output word    rs1Val,
    output word    rs2Val
);

    word regs [32];

    always_ff @(posedge clk) begin
        if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // x0 is hardwired, same-cycle write shows through
    assign rs1Val = (rs1Addr == '0) ? '0 :
                    (writeEn && rs1Addr == writeAddr) ? writeData : regs[rs1Addr];
    assign rs2Val = (rs2Addr == '0) ? '0 :
                    (writeEn && rs2Addr == writeAddr) ? writeData : regs[rs2Addr];

    // A write addressed to x0 leaves its stored entry untouched
    zeroStaysZero: assert property (@(posedge clk) disable iff (!rstN)
        writeEn && writeAddr == '0 |=> regs[0] === $past(regs[0]));

endmodule

//--- source/fetchUnit.sv
// Fetch stage: program counter and the register into R, instantiated by the core top
`timescale 1ns/1ns
module fetchUnit import isaPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    hazardIf.stage   hz,
    input  word      branchTarget,
    input  instrWord instr,
    output word      pc,
    output word      pcR,
    output instrWord instrR
);

    word pcNext;

    // Redirect outranks the load-use hold
    always_comb begin
        if (hz.branchTaken) begin
            pcNext = branchTarget;
        end else if (hz.stallFront) begin
            pcNext = pc;
        end else begin
            pcNext = pc + pcStep;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
        end else begin
            pc <= pcNext;
        end
    end

    // All-zero instruction decodes as a bubble
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcR    <= resetPc;
            instrR <= '0;
        end else if (hz.flushIr) begin
            instrR <= '0;
        end else if (!hz.stallFront) begin
            pcR    <= pc;
            instrR <= instr;
        end
    end

    // A taken branch always kills the fetched instruction, stall or not
    flushBeatsStall: assert property (@(posedge clk) disable iff (!rstN)
        hz.branchTaken |=> instrR == '0);

endmodule

//--- source/decodeStage.sv
// Register read and decode stage with the register file and the register into C
`timescale 1ns/1ns
module decodeStage import isaPkg::*, controlPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    hazardIf.stage    hz,
    input  word       pcR,
    input  instrWord  instrR,
    input  logic      writeEn,
    input  regAddr    writeAddr,
    input  word       writeData,
    output ctrlBundle ctrlC,
    output word       rs1ValC,
    output word       rs2ValC,
    output word       immC,
    output word       branchTargetC,
    output regAddr    rdAddrC
);

    opcodeT     opcode;
    logic [2:0] funct3;
    ctrlBundle  ctrlR;
    word        immR;
    word        rs1ValR;
    word        rs2ValR;

    assign opcode     = instrR[6:0];
    assign funct3     = instrR[14:12];
    assign hz.rs1Addr = instrR[19:15];
    assign hz.rs2Addr = instrR[24:20];

    registerFile regFile (
        .clk,
        .rstN,
        .rs1Addr(hz.rs1Addr),
        .rs2Addr(hz.rs2Addr),
        .writeAddr,
        .writeEn,
        .writeData,
        .rs1Val(rs1ValR),
        .rs2Val(rs2ValR)
    );

    // Anything outside the subset stays a bubble
    always_comb begin
        ctrlR = ctrlBubble;
        case (opcode)
            opRegReg, opRegImm: begin
                ctrlR.regWrite    = 1'b1;
                ctrlR.operandBSrc = (opcode == opRegImm) ? srcBImm : srcBReg;
                case (funct3)
                    f3AddSub: ctrlR.aluOp = (opcode == opRegReg && instrR[30]) ? aluSub : aluAdd;
                    f3Slt:    ctrlR.aluOp = aluSlt;
                    f3Xor:    ctrlR.aluOp = aluXor;
                    f3Or:     ctrlR.aluOp = aluOr;
                    f3And:    ctrlR.aluOp = aluAnd;
                    default:  ctrlR = ctrlBubble;
                endcase
            end
            opLui: begin
                ctrlR.regWrite  = 1'b1;
                ctrlR.resultSrc = resultImm;
            end
            opLoad: begin
                if (funct3 == f3Word) begin
                    ctrlR.operandBSrc = srcBImm;
                    ctrlR.resultSrc   = resultMem;
                    ctrlR.regWrite    = 1'b1;
                    ctrlR.memRead     = 1'b1;
                end
            end
            opStore: begin
                if (funct3 == f3Word) begin
                    ctrlR.operandBSrc = srcBImm;
                    ctrlR.memWrite    = 1'b1;
                end
            end
            opBranch: begin
                if (funct3 == f3Beq || funct3 == f3Bne) begin
                    ctrlR.isBranch      = 1'b1;
                    ctrlR.branchOnEqual = (funct3 == f3Beq);
                end
            end
            default: ctrlR = ctrlBubble;
        endcase
    end

    // Immediate format follows the opcode, I-type otherwise
    always_comb begin
        case (opcode)
            opStore:  immR = {{20{instrR[31]}}, instrR[31:25], instrR[11:7]};
            opBranch: immR = {{19{instrR[31]}}, instrR[31], instrR[7],
                              instrR[30:25], instrR[11:8], 1'b0};
            opLui:    immR = {instrR[31:12], 12'b0};
            default:  immR = {{20{instrR[31]}}, instrR[31:20]};
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlC <= ctrlBubble;
        end else if (hz.flushRc) begin
            ctrlC <= ctrlBubble;
        end else begin
            ctrlC <= ctrlR;
        end
    end

    always_ff @(posedge clk) begin
        rs1ValC       <= rs1ValR;
        rs2ValC       <= rs2ValR;
        immC          <= immR;
        branchTargetC <= pcR + immR;
        rdAddrC       <= instrR[11:7];
    end

endmodule

//--- source/executeStage.sv
// Compute stage: forwarding, ALU, branch decision and the register into M
`timescale 1ns/1ns
module executeStage import isaPkg::*, controlPkg::*; (
    input  logic         clk,
    input  logic         rstN,
    hazardIf.stage       hz,
    input  ctrlBundle    ctrlC,
    input  word          rs1ValC,
    input  word          rs2ValC,
    input  word          immC,
    input  word          branchTargetC,
    input  regAddr       rdAddrC,
    input  word          wbValue,
    output word          branchTarget,
    output word          resultM,
    output word          storeDataM,
    output memCtrlBundle ctrlM,
    output regAddr       rdAddrM
);

    word operandA;
    word operandBReg;
    word operandB;
    word aluOut;
    word resultC;

    // Register path of operand B doubles as store data
    always_comb begin
        case (hz.forwardA)
            fwdFromM: operandA = resultM;
            fwdFromW: operandA = wbValue;
            default:  operandA = rs1ValC;
        endcase
        case (hz.forwardB)
            fwdFromM: operandBReg = resultM;
            fwdFromW: operandBReg = wbValue;
            default:  operandBReg = rs2ValC;
        endcase
    end

    assign operandB = (ctrlC.operandBSrc == srcBImm) ? immC : operandBReg;

    always_comb begin
        case (ctrlC.aluOp)
            aluSub:  aluOut = operandA - operandB;
            aluAnd:  aluOut = operandA & operandB;
            aluOr:   aluOut = operandA | operandB;
            aluXor:  aluOut = operandA ^ operandB;
            aluSlt:  aluOut = {31'b0, $signed(operandA) < $signed(operandB)};
            default: aluOut = operandA + operandB;
        endcase
    end

    // LUI passes its immediate straight through
    assign resultC = (ctrlC.resultSrc == resultImm) ? immC : aluOut;

    // BEQ and BNE
    assign hz.branchTaken = ctrlC.isBranch &&
                            ((operandA == operandBReg) == ctrlC.branchOnEqual);
    assign branchTarget   = branchTargetC;

    assign hz.rdAddrC   = rdAddrC;
    assign hz.regWriteC = ctrlC.regWrite;
    assign hz.memReadC  = ctrlC.memRead;
    assign hz.rdAddrM   = rdAddrM;
    assign hz.regWriteM = ctrlM.regWrite;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlM <= memCtrlBubble;
        end else begin
            ctrlM.resultSrc <= ctrlC.resultSrc;
            ctrlM.regWrite  <= ctrlC.regWrite;
            ctrlM.memRead   <= ctrlC.memRead;
            ctrlM.memWrite  <= ctrlC.memWrite;
        end
    end

    always_ff @(posedge clk) begin
        resultM    <= resultC;
        storeDataM <= operandBReg;
        rdAddrM    <= rdAddrC;
    end

    // Decode never issues a load and a store as one instruction
    oneMemOp: assert property (@(posedge clk) disable iff (!rstN)
        !(ctrlM.memRead && ctrlM.memWrite));

endmodule

//--- source/memWriteback.sv
// Register from M into W and the register file write port, also the W forward source
`timescale 1ns/1ns
module memWriteback import isaPkg::*, controlPkg::*; (
    input  logic         clk,
    input  logic         rstN,
    input  word          resultM,
    input  word          memReadData,
    input  memCtrlBundle ctrlM,
    input  regAddr       rdAddrM,
    output logic         writeEn,
    output regAddr       writeAddr,
    output word          writeData
);

    resultSrcT resultSrcW;
    word       resultW;
    word       readDataW;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resultSrcW <= resultAlu;
            writeEn    <= 1'b0;
        end else begin
            resultSrcW <= ctrlM.resultSrc;
            writeEn    <= ctrlM.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        resultW   <= resultM;
        readDataW <= memReadData;
        writeAddr <= rdAddrM;
    end

    // Loads return the memory word, the rest the compute result
    assign writeData = (resultSrcW == resultMem) ? readDataW : resultW;

endmodule

//--- source/hazardUnit.sv
// Forward selection, load-use stall and flush control for the pipeline
`timescale 1ns/1ns
module hazardUnit import isaPkg::*, controlPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    hazardIf.ctrl hz
);

    // Nearest producer wins, x0 never forwarded
    function automatic forwardSelT pickForward(input regAddr src, input regAddr rdC,
                                               input logic wrC, input regAddr rdM,
                                               input logic wrM);
        if (src == '0) begin
            return fwdNone;
        end else if (wrC && rdC == src) begin
            return fwdFromM;
        end else if (wrM && rdM == src) begin
            return fwdFromW;
        end
        return fwdNone;
    endfunction

    // Today's C result sits in M and today's M result in W once R moves into C
    always_ff @(posedge clk) begin
        hz.forwardA <= pickForward(hz.rs1Addr, hz.rdAddrC, hz.regWriteC,
                                   hz.rdAddrM, hz.regWriteM);
        hz.forwardB <= pickForward(hz.rs2Addr, hz.rdAddrC, hz.regWriteC,
                                   hz.rdAddrM, hz.regWriteM);
    end

    // Load result is not ready until W
    assign hz.stallFront = hz.memReadC && hz.rdAddrC != '0 &&
                           (hz.rdAddrC == hz.rs1Addr || hz.rdAddrC == hz.rs2Addr);
    assign hz.flushIr    = hz.branchTaken;
    assign hz.flushRc    = hz.branchTaken || hz.stallFront;

    // The producer picked for an M forward never targets x0
    noZeroForward: assert property (@(posedge clk) disable iff (!rstN)
        (hz.forwardA == fwdFromM || hz.forwardB == fwdFromM) |-> hz.rdAddrM != '0);

endmodule

//--- source/computeCore.sv
// Five-stage RV32I subset core, top level with external instruction and data memory ports
`timescale 1ns/1ns
module computeCore import isaPkg::*, controlPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    output word      pc,
    input  instrWord instr,
    output logic     memEn,
    output logic     memWriteEn,
    output word      memAddr,
    output word      memWriteData,
    input  word      memReadData
);

    hazardIf hz ();

    word          pcR;
    instrWord     instrR;
    word          branchTarget;
    ctrlBundle    ctrlC;
    word          rs1ValC;
    word          rs2ValC;
    word          immC;
    word          branchTargetC;
    regAddr       rdAddrC;
    word          resultM;
    word          storeDataM;
    memCtrlBundle ctrlM;
    regAddr       rdAddrM;
    logic         writeEn;
    regAddr       writeAddr;
    word          writeData;

    fetchUnit fetch (
        .clk, .rstN, .hz, .branchTarget, .instr, .pc, .pcR, .instrR
    );

    decodeStage decode (
        .clk, .rstN, .hz, .pcR, .instrR,
        .writeEn, .writeAddr, .writeData,
        .ctrlC, .rs1ValC, .rs2ValC, .immC, .branchTargetC, .rdAddrC
    );

    executeStage execute (
        .clk, .rstN, .hz, .ctrlC, .rs1ValC, .rs2ValC, .immC, .branchTargetC, .rdAddrC,
        .wbValue(writeData),
        .branchTarget, .resultM, .storeDataM, .ctrlM, .rdAddrM
    );

    memWriteback writeback (
        .clk, .rstN, .resultM, .memReadData, .ctrlM, .rdAddrM,
        .writeEn, .writeAddr, .writeData
    );

    hazardUnit hazards (
        .clk, .rstN, .hz
    );

    // Data memory is driven from M
    assign memEn        = ctrlM.memRead || ctrlM.memWrite;
    assign memWriteEn   = ctrlM.memWrite;
    assign memAddr      = resultM;
    assign memWriteData = storeDataM;

endmodule

//--- dv/computeCoreTb.sv
// Directed testbench for the pipelined core, run as top module with behavioral memories
`timescale 1ns/1ns
module computeCoreTb;

    localparam int clockPeriod = 20;
    localparam int cycleLimit  = 200;
    localparam int testTotal   = 6;

    logic        clk;
    logic        rstN;
    logic [31:0] pc;
    logic [31:0] instr;
    logic        memEn;
    logic        memWriteEn;
    logic [31:0] memAddr;
    logic [31:0] memWriteData;
    logic [31:0] memReadData;

    logic [31:0] progMem [256];
    logic [31:0] dataMem [512];
    logic [31:0] storeAddr [$];
    logic [31:0] storeData [$];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [31:0] rngState;
    int          progLen;
    int          errorCount;
    int          testsRun;
    string       testName;

    computeCore u_dut (
        .clk, .rstN, .pc, .instr, .memEn, .memWriteEn, .memAddr, .memWriteData, .memReadData
    );

    // Both memories answer in the same cycle
    assign instr       = progMem[pc[9:2]];
    assign memReadData = dataMem[memAddr[10:2]];

    initial begin
        clk = 1'b0;
        forever #(clockPeriod / 2) clk = ~clk;
    end

    // Stores taken mid-cycle while M is stable
    always @(negedge clk) begin
        if (rstN && memWriteEn) begin
            storeAddr.push_back(memAddr);
            storeData.push_back(memWriteData);
            dataMem[memAddr[10:2]] <= memWriteData;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic logic [31:0] signExtend12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] encodeRType(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encodeIType(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encodeStore(input logic [11:0] off, input logic [4:0] rs2,
                                                input logic [4:0] rs1);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encodeBranch(input logic [12:0] off, input logic [4:0] rs2,
                                                 input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encodeLui(input logic [19:0] upper, input logic [4:0] rd);
        return {upper, rd, 7'b0110111};
    endfunction

    // Op index: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 slt
    function automatic logic [2:0] aluFunct3(input int op);
        case (op)
            2: return 3'b111;
            3: return 3'b110;
            4: return 3'b100;
            5: return 3'b010;
            default: return 3'b000;
        endcase
    endfunction

    function automatic logic [31:0] aluReference(input int op, input logic [31:0] a,
                                                 input logic [31:0] b);
        case (op)
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return a ^ b;
            5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return a + b;
        endcase
    endfunction

    task automatic emit(input logic [31:0] code);
        progMem[progLen] = code;
        progLen++;
    endtask

    // LUI takes the rounded upper part so the signed ADDI lands on the value
    task automatic loadConstant(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        emit(encodeLui(upper[31:12], rd));
        emit(encodeIType(value[11:0], rd, 3'b000, rd, 7'b0010011));
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic reportMismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
        errorCount++;
        $display("[FAIL] %s %s: expected %h, actual %h", testName, what, expected, actual);
    endtask

    task automatic clearMemories();
        for (int i = 0; i < 256; i++) begin
            progMem[i] = '0;
        end
        for (int i = 0; i < 512; i++) begin
            dataMem[i] = 32'h5a00_0000 | i;
        end
        storeAddr.delete();
        storeData.delete();
        expAddr.delete();
        expData.delete();
        progLen = 0;
    endtask

    task automatic beginTest(input string name);
        @(negedge clk);
        rstN     = 1'b0;
        testName = name;
        testsRun++;
        clearMemories();
    endtask

    task automatic releaseReset();
        repeat (4) @(negedge clk);
        rstN = 1'b1;
    endtask

    task automatic emitHalt();
        emit(encodeBranch(13'd0, 5'd0, 5'd0, 3'b000));
    endtask

    // Second arrival at the closing branch means it has left C, so older stores are done
    task automatic runToHalt();
        logic [31:0] haltAddr;
        logic        wasAtHalt;
        int          entries;
        int          cycles;
        haltAddr  = (progLen - 1) * 4;
        wasAtHalt = 1'b0;
        entries   = 0;
        cycles    = 0;
        while (entries < 2) begin
            if (cycles == cycleLimit) begin
                errorCount++;
                $display("Timeout in %s: the core never looped on its closing branch",
                         testName);
                return;
            end
            @(negedge clk);
            cycles++;
            if (pc == haltAddr && !wasAtHalt) begin
                entries++;
            end
            wasAtHalt = (pc == haltAddr);
        end
    endtask

    task automatic checkStores();
        int n;
        if (storeAddr.size() != expAddr.size()) begin
            reportMismatch("store count", expAddr.size(), storeAddr.size());
        end
        n = (storeAddr.size() < expAddr.size()) ? storeAddr.size() : expAddr.size();
        for (int i = 0; i < n; i++) begin
            if (storeAddr[i] !== expAddr[i]) begin
                reportMismatch($sformatf("store %0d address", i), expAddr[i], storeAddr[i]);
            end
            if (storeData[i] !== expData[i]) begin
                reportMismatch($sformatf("store %0d data", i), expData[i], storeData[i]);
            end
        end
    endtask

    task automatic runProgram();
        emitHalt();
        releaseReset();
        runToHalt();
        checkStores();
    endtask

    task automatic resetCheck();
        beginTest("resetCheck");
        emit(encodeIType(12'h05a, 5'd0, 3'b000, 5'd1, 7'b0010011));
        emit(encodeStore(12'h010, 5'd1, 5'd0));
        expectStore(32'h10, 32'h5a);
        emitHalt();
        releaseReset();
        if (pc !== 32'h0) begin
            reportMismatch("pc after reset", 32'h0, pc);
        end
        // Store fetched at pc 4 reaches M in cycle 4
        for (int cycle = 0; cycle <= 4; cycle++) begin
            if (memEn !== (cycle == 4)) begin
                reportMismatch($sformatf("memEn in cycle %0d", cycle), cycle == 4, memEn);
            end
            if (memWriteEn !== (cycle == 4)) begin
                reportMismatch($sformatf("memWriteEn in cycle %0d", cycle), cycle == 4,
                               memWriteEn);
            end
            @(negedge clk);
        end
        runToHalt();
        checkStores();
    endtask

    task automatic aluArithmetic();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [11:0] offset;
        beginTest("aluArithmetic");
        offset = 12'h0;
        for (int round = 0; round < 3; round++) begin
            a = nextRandom();
            b = nextRandom();
            loadConstant(5'd1, a);
            loadConstant(5'd2, b);
            for (int op = 0; op < 6; op++) begin
                emit(encodeRType((op == 1) ? 7'b0100000 : 7'b0000000, 5'd2, 5'd1,
                                 aluFunct3(op), 5'd3));
                emit(encodeStore(offset, 5'd3, 5'd0));
                expectStore({20'h0, offset}, aluReference(op, a, b));
                offset = offset + 12'd4;
                // No immediate form of SUB
                if (op != 1) begin
                    imm = nextRandom();
                    emit(encodeIType(imm[11:0], 5'd1, aluFunct3(op), 5'd4, 7'b0010011));
                    emit(encodeStore(offset, 5'd4, 5'd0));
                    expectStore({20'h0, offset}, aluReference(op, a, signExtend12(imm[11:0])));
                    offset = offset + 12'd4;
                end
            end
        end
        runProgram();
    endtask

    task automatic forwarding();
        logic [31:0] t1;
        logic [31:0] t2;
        logic [31:0] v5;
        logic [31:0] v6;
        logic [31:0] v7;
        beginTest("forwarding");
        t1 = nextRandom();
        t2 = nextRandom();
        v5 = signExtend12(t1[11:0]);
        v6 = v5 + signExtend12(t2[11:0]);
        v7 = v6 + v5;
        emit(encodeIType(t1[11:0], 5'd0, 3'b000, 5'd5, 7'b0010011));
        emit(encodeIType(t2[11:0], 5'd5, 3'b000, 5'd6, 7'b0010011));
        emit(encodeRType(7'b0000000, 5'd5, 5'd6, 3'b000, 5'd7));
        emit(encodeStore(12'h100, 5'd7, 5'd0));
        emit(encodeStore(12'h104, 5'd7, 5'd0));
        emit(encodeRType(7'b0100000, 5'd6, 5'd7, 3'b000, 5'd9));
        emit(encodeIType(12'h200, 5'd0, 3'b000, 5'd8, 7'b0010011));
        emit(encodeStore(12'h004, 5'd9, 5'd8));
        emit(encodeStore(12'h108, 5'd6, 5'd0));
        expectStore(32'h100, v7);
        expectStore(32'h104, v7);
        expectStore(32'h204, v7 - v6);
        expectStore(32'h108, v6);
        runProgram();
    endtask

    task automatic loadUse();
        logic [31:0] m0;
        logic [31:0] m1;
        logic [31:0] t;
        logic [31:0] addend;
        beginTest("loadUse");
        m0           = nextRandom();
        m1           = nextRandom();
        t            = nextRandom();
        addend       = signExtend12(t[11:0]);
        dataMem[16]  = m0;
        dataMem[17]  = m1;
        emit(encodeIType(t[11:0], 5'd0, 3'b000, 5'd1, 7'b0010011));
        emit(encodeIType(12'h040, 5'd0, 3'b010, 5'd2, 7'b0000011));
        emit(encodeRType(7'b0000000, 5'd1, 5'd2, 3'b000, 5'd3));
        emit(encodeStore(12'h080, 5'd3, 5'd0));
        // Loaded register used directly as store data
        emit(encodeIType(12'h044, 5'd0, 3'b010, 5'd4, 7'b0000011));
        emit(encodeStore(12'h084, 5'd4, 5'd0));
        emit(encodeIType(12'h080, 5'd0, 3'b010, 5'd5, 7'b0000011));
        emit(encodeRType(7'b0000000, 5'd5, 5'd1, 3'b000, 5'd6));
        emit(encodeStore(12'h088, 5'd6, 5'd0));
        expectStore(32'h80, m0 + addend);
        expectStore(32'h84, m1);
        expectStore(32'h88, m0 + addend + addend);
        runProgram();
    endtask

    task automatic branches();
        logic [31:0] t;
        logic [31:0] v;
        beginTest("branches");
        t = nextRandom();
        v = signExtend12(t[11:0]);
        emit(encodeIType(t[11:0], 5'd0, 3'b000, 5'd1, 7'b0010011));
        emit(encodeIType(t[11:0], 5'd0, 3'b000, 5'd2, 7'b0010011));
        emit(encodeIType(12'h001, 5'd1, 3'b000, 5'd3, 7'b0010011));
        // Taken BEQ, then taken BNE, each over two stores
        emit(encodeBranch(13'd12, 5'd2, 5'd1, 3'b000));
        emit(encodeStore(12'h300, 5'd1, 5'd0));
        emit(encodeStore(12'h304, 5'd1, 5'd0));
        emit(encodeBranch(13'd12, 5'd3, 5'd1, 3'b001));
        emit(encodeStore(12'h308, 5'd1, 5'd0));
        emit(encodeStore(12'h30c, 5'd1, 5'd0));
        emit(encodeBranch(13'd8, 5'd3, 5'd1, 3'b000));
        emit(encodeStore(12'h310, 5'd3, 5'd0));
        emit(encodeBranch(13'd8, 5'd2, 5'd1, 3'b001));
        emit(encodeStore(12'h314, 5'd2, 5'd0));
        expectStore(32'h310, v + 32'd1);
        expectStore(32'h314, v);
        runProgram();
        foreach (storeAddr[i]) begin
            if (storeAddr[i] >= 32'h300 && storeAddr[i] <= 32'h30c) begin
                errorCount++;
                $display("Error in %s: a skipped store wrote address %h", testName,
                         storeAddr[i]);
            end
        end
    endtask

    task automatic zeroRegister();
        logic [31:0] t;
        beginTest("zeroRegister");
        t = nextRandom();
        emit(encodeIType(t[11:0] | 12'h001, 5'd0, 3'b000, 5'd0, 7'b0010011));
        emit(encodeStore(12'h120, 5'd0, 5'd0));
        emit(encodeIType(12'h055, 5'd0, 3'b000, 5'd1, 7'b0010011));
        emit(encodeRType(7'b0000000, 5'd1, 5'd1, 3'b000, 5'd0));
        emit(encodeStore(12'h124, 5'd0, 5'd0));
        emit(encodeLui(t[31:12] | 20'h1, 5'd0));
        emit(encodeRType(7'b0000000, 5'd1, 5'd0, 3'b000, 5'd2));
        emit(encodeStore(12'h128, 5'd2, 5'd0));
        expectStore(32'h120, 32'h0);
        expectStore(32'h124, 32'h0);
        expectStore(32'h128, 32'h55);
        runProgram();
    endtask

    initial begin
        rstN       = 1'b0;
        rngState   = 32'h2d44_c294;
        errorCount = 0;
        testsRun   = 0;
        clearMemories();
        resetCheck();
        aluArithmetic();
        forwarding();
        loadUse();
        branches();
        zeroRegister();
        $display("Tests run: %0d, errors: %0d", testsRun, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Every test fits well inside its share of cycles
    initial begin
        #(testTotal * cycleLimit * clockPeriod);
        $display("Watchdog expired before all tests finished");
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- computeCore.f
source/isaPkg.sv
source/controlPkg.sv
source/hazardIf.sv
source/registerFile.sv
source/fetchUnit.sv
source/decodeStage.sv
source/executeStage.sv
source/memWriteback.sv
source/hazardUnit.sv
source/computeCore.sv
dv/computeCoreTb.sv
